//--- verilog/cs_pkg.sv
package cs_pkg;

   // Control store geometry
   localparam int cs_addr_w = 12;      // Microaddress bits
   localparam int cs_depth  = 4096;    // Words in the WCS
   localparam int cs_word_w = 64;      // Microword bits

   // Host side slicing of a microword
   localparam int idb_w      = 16;     // Internal data bus width
   localparam int cs_lanes   = 4;      // Slices per word
   localparam int lane_sel_w = 2;      // Slice index bits

   // Fetch return buffer
   localparam int ret_depth = 2;       // Buffered plus in-flight words

   // Host port controller states
   localparam int hp_state_w = 2;
   localparam logic [hp_state_w-1:0] hp_idle = 2'd0;  // Waiting for a command
   localparam logic [hp_state_w-1:0] hp_req  = 2'd1;  // Request out to arbiter
   localparam logic [hp_state_w-1:0] hp_rsp  = 2'd2;  // Read data pending or held

endpackage

//--- verilog/cs_bus_if.sv
`timescale 1ns/1ps

interface cs_bus_if;

   // Request side
   logic                         req_valid;
   logic                         req_ready;
   logic [cs_pkg::cs_addr_w-1:0] addr;
   logic [cs_pkg::cs_lanes-1:0]  lane_we;   // All zero is a read
   logic [cs_pkg::cs_word_w-1:0] wdata;

   // Read return, no backpressure
   logic                         rsp_valid;
   logic [cs_pkg::cs_word_w-1:0] rdata;

   // Side that asks for WCS access
   modport requester (
      output req_valid, addr, lane_we, wdata,
      input  req_ready, rsp_valid, rdata
   );

   // Arbiter end of a requester's link
   modport arbiter (
      input  req_valid, addr, lane_we, wdata,
      output req_ready, rsp_valid, rdata
   );

   // The WCS itself
   modport memory (
      input  req_valid, addr, lane_we, wdata,
      output req_ready, rsp_valid, rdata
   );

endinterface

//--- verilog/cs_wcs.sv
`timescale 1ns/1ps

module cs_wcs (
   input logic          clk,
   cs_bus_if.memory     mem
);

   // Writable control store, no reset contents
   logic [cs_pkg::cs_word_w-1:0] store [cs_pkg::cs_depth];

   logic rd_req;

   assign mem.req_ready = 1'b1;                   // Single cycle access, never stalls
   assign rd_req = mem.req_valid & ~|mem.lane_we; // No lane enabled means read

   // Four lane strobes, one per 16-bit slice
   always_ff @(posedge clk) begin
      if (mem.req_valid) begin
         for (int l = 0; l < cs_pkg::cs_lanes; l++) begin
            if (mem.lane_we[l]) begin
               store[mem.addr][l*cs_pkg::idb_w +: cs_pkg::idb_w] <=
                  mem.wdata[l*cs_pkg::idb_w +: cs_pkg::idb_w];
            end
         end
      end
   end

   // Registered read port
   always_ff @(posedge clk) begin
      if (rd_req) begin
         mem.rdata <= store[mem.addr];
      end
      mem.rsp_valid <= rd_req;   // Owner is qualified in the arbiter
   end

endmodule

//--- verilog/cs_arbiter.sv
`timescale 1ns/1ps

module cs_arbiter (
   input logic          clk,
   input logic          rst,
   cs_bus_if.arbiter    fetch_bus,
   cs_bus_if.arbiter    host_bus,
   cs_bus_if.requester  mem_bus
);

   logic last_host_q;    // Round-robin pointer, set when host won last
   logic grant_fetch;
   logic grant_host;
   logic rsp_fetch_q;    // Read owner for the cycle after the grant
   logic rsp_host_q;

   // Ready depends on the other side only, so no loop through the requester
   // Host blocks fetch only when host is due
   assign fetch_bus.req_ready = mem_bus.req_ready & ~(host_bus.req_valid & ~last_host_q);
   // Fetch blocks host only when fetch is due
   assign host_bus.req_ready  = mem_bus.req_ready & ~(fetch_bus.req_valid & last_host_q);

   assign grant_fetch = fetch_bus.req_valid & fetch_bus.req_ready;
   assign grant_host  = host_bus.req_valid & host_bus.req_ready;

   // Winner onto the memory link
   assign mem_bus.req_valid = grant_fetch | grant_host;
   always_comb begin
      if (grant_host) begin
         mem_bus.addr    = host_bus.addr;
         mem_bus.lane_we = host_bus.lane_we;
         mem_bus.wdata   = host_bus.wdata;
      end else begin
         mem_bus.addr    = fetch_bus.addr;       // Fetch is the default path
         mem_bus.lane_we = fetch_bus.lane_we;
         mem_bus.wdata   = fetch_bus.wdata;
      end
   end

   // Pointer flips to whoever was just served
   always_ff @(posedge clk) begin
      if (rst) begin
         last_host_q <= 1'b1;   // Fetch wins first tie
      end else if (grant_fetch) begin
         last_host_q <= 1'b0;
      end else if (grant_host) begin
         last_host_q <= 1'b1;
      end
   end

   // Writes return nothing
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_fetch_q <= 1'b0;
         rsp_host_q  <= 1'b0;
      end else begin
         rsp_fetch_q <= grant_fetch & ~|fetch_bus.lane_we;
         rsp_host_q  <= grant_host & ~|host_bus.lane_we;
      end
   end

   // Steer the pulse, fan out the data
   assign fetch_bus.rsp_valid = mem_bus.rsp_valid & rsp_fetch_q;
   assign host_bus.rsp_valid  = mem_bus.rsp_valid & rsp_host_q;
   assign fetch_bus.rdata     = mem_bus.rdata;
   assign host_bus.rdata      = mem_bus.rdata;

endmodule

//--- verilog/cs_fetch_port.sv
`timescale 1ns/1ps

module cs_fetch_port (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         ua_valid,
   output logic                         ua_ready,
   input  logic [cs_pkg::cs_addr_w-1:0] ua,
   output logic                         csbits_valid,
   input  logic                         csbits_ready,
   output logic [cs_pkg::cs_word_w-1:0] csbits,
   cs_bus_if.requester                  bus
);

   logic [1:0] credit_q;    // Buffered plus in-flight words
   logic [1:0] fill_q;      // Words sitting in the buffer
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic       has_credit;
   logic       issue;
   logic       push;
   logic       pop;

   // Return buffer, payload only
   logic [cs_pkg::cs_word_w-1:0] fifo_q [cs_pkg::ret_depth];

   assign has_credit = credit_q < 2'(cs_pkg::ret_depth);

   // Microaddress goes straight out as a read
   assign bus.req_valid = ua_valid & has_credit;
   assign bus.addr      = ua;
   assign bus.lane_we   = '0;          // Fetch never writes
   assign bus.wdata     = '0;
   assign ua_ready      = bus.req_ready & has_credit;

   assign issue = bus.req_valid & bus.req_ready;
   assign push  = bus.rsp_valid;       // Room reserved by credit at issue
   assign pop   = csbits_valid & csbits_ready;

   assign csbits_valid = fill_q != 2'd0;
   assign csbits       = fifo_q[rd_ptr_q];    // Oldest word first

   // Credit returns when the word leaves, not when it lands
   always_ff @(posedge clk) begin
      if (rst) begin
         credit_q <= 2'd0;
      end else begin
         credit_q <= credit_q + 2'(issue) - 2'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         fill_q   <= 2'd0;
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
      end else begin
         fill_q   <= fill_q + 2'(push) - 2'(pop);
         wr_ptr_q <= wr_ptr_q ^ push;
         rd_ptr_q <= rd_ptr_q ^ pop;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_q[wr_ptr_q] <= bus.rdata;
      end
   end

endmodule

//--- verilog/cs_host_port.sv
`timescale 1ns/1ps

module cs_host_port (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cmd_valid,
   output logic                          cmd_ready,
   input  logic                          cmd_write,
   input  logic [cs_pkg::cs_addr_w-1:0]  cmd_addr,
   input  logic [cs_pkg::lane_sel_w-1:0] cmd_lane,
   input  logic [cs_pkg::idb_w-1:0]      cmd_data,
   output logic                          rd_valid,
   input  logic                          rd_ready,
   output logic [cs_pkg::idb_w-1:0]      rd_data,
   cs_bus_if.requester                   bus
);

   logic [cs_pkg::hp_state_w-1:0] state_q;
   logic                          write_q;
   logic [cs_pkg::cs_addr_w-1:0]  addr_q;
   logic [cs_pkg::lane_sel_w-1:0] lane_q;
   logic [cs_pkg::idb_w-1:0]      data_q;    // Write slice, later the read slice
   logic                          have_q;    // Read slice captured and held
   logic [cs_pkg::idb_w-1:0]      rsp_slice;

   assign cmd_ready = state_q == cs_pkg::hp_idle;

   // One request per command
   assign bus.req_valid = state_q == cs_pkg::hp_req;
   assign bus.addr      = addr_q;
   assign bus.lane_we   = write_q ?
                          {{(cs_pkg::cs_lanes-1){1'b0}}, 1'b1} << lane_q : '0;
   assign bus.wdata     = {cs_pkg::cs_lanes{data_q}};   // Same slice in every lane

   assign rsp_slice = bus.rdata[lane_q*cs_pkg::idb_w +: cs_pkg::idb_w];

   // Live data on the return cycle, held copy after that
   assign rd_valid = (state_q == cs_pkg::hp_rsp) & (bus.rsp_valid | have_q);
   assign rd_data  = have_q ? data_q : rsp_slice;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= cs_pkg::hp_idle;
         have_q  <= 1'b0;
      end else begin
         case (state_q)
            cs_pkg::hp_idle:
               if (cmd_valid) state_q <= cs_pkg::hp_req;
            cs_pkg::hp_req:
               if (bus.req_ready) begin
                  state_q <= write_q ? cs_pkg::hp_idle : cs_pkg::hp_rsp;
               end
            cs_pkg::hp_rsp:
               if (rd_valid && rd_ready) begin
                  state_q <= cs_pkg::hp_idle;
                  have_q  <= 1'b0;
               end else if (bus.rsp_valid) begin
                  have_q <= 1'b1;   // Host stalled, keep the slice
               end
            default:
               state_q <= cs_pkg::hp_idle;
         endcase
      end
   end

   // Command latch and read capture
   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         write_q <= cmd_write;
         addr_q  <= cmd_addr;
         lane_q  <= cmd_lane;
         data_q  <= cmd_data;
      end else if (state_q == cs_pkg::hp_rsp && bus.rsp_valid) begin
         data_q  <= rsp_slice;
      end
   end

endmodule

//--- verilog/control_store.sv
`timescale 1ns/1ps

module control_store (
   input  logic                          clk,
   input  logic                          rst,

   // Microaddress from the sequencer
   input  logic                          ua_valid,
   output logic                          ua_ready,
   input  logic [cs_pkg::cs_addr_w-1:0]  ua,

   // Microword out
   output logic                          csbits_valid,
   input  logic                          csbits_ready,
   output logic [cs_pkg::cs_word_w-1:0]  csbits,

   // Host commands from the data-bus side
   input  logic                          cmd_valid,
   output logic                          cmd_ready,
   input  logic                          cmd_write,
   input  logic [cs_pkg::cs_addr_w-1:0]  cmd_addr,
   input  logic [cs_pkg::lane_sel_w-1:0] cmd_lane,
   input  logic [cs_pkg::idb_w-1:0]      cmd_data,

   // Host readback, reads only
   output logic                          rd_valid,
   input  logic                          rd_ready,
   output logic [cs_pkg::idb_w-1:0]      rd_data
);

   cs_bus_if fetch_bus ();   // Fetch port to arbiter
   cs_bus_if host_bus ();    // Host port to arbiter
   cs_bus_if mem_bus ();     // Arbiter to WCS

   cs_fetch_port i_fetch_port (
      .clk          (clk),
      .rst          (rst),
      .ua_valid     (ua_valid),
      .ua_ready     (ua_ready),
      .ua           (ua),
      .csbits_valid (csbits_valid),
      .csbits_ready (csbits_ready),
      .csbits       (csbits),
      .bus          (fetch_bus)
   );

   cs_host_port i_host_port (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_write (cmd_write),
      .cmd_addr  (cmd_addr),
      .cmd_lane  (cmd_lane),
      .cmd_data  (cmd_data),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .rd_data   (rd_data),
      .bus       (host_bus)
   );

   cs_arbiter i_arbiter (
      .clk       (clk),
      .rst       (rst),
      .fetch_bus (fetch_bus),
      .host_bus  (host_bus),
      .mem_bus   (mem_bus)
   );

   cs_wcs i_wcs (
      .clk (clk),
      .mem (mem_bus)
   );

endmodule

//--- testbench/cs_props.sv
`timescale 1ns/1ps

module cs_props (
   input logic        clk,
   input logic        rst,
   input logic        fetch_grant,    // Transfers on the arbiter links
   input logic        host_grant,
   input logic        fetch_read,
   input logic        host_read,
   input logic        fetch_rsp,
   input logic        host_rsp,
   input logic        ua_valid,
   input logic        ua_ready,
   input logic [11:0] ua,
   input logic        csbits_valid,
   input logic        csbits_ready,
   input logic [63:0] csbits,
   input logic        cmd_valid,
   input logic        cmd_ready,
   input logic [30:0] cmd_bits,       // Write flag, address, lane and slice
   input logic        rd_valid,
   input logic        rd_ready,
   input logic [15:0] rd_data
);

   // One WCS access per cycle
   one_grant: assert property (@(posedge clk) disable iff (rst)
      !(fetch_grant && host_grant)) else $error("arbiter granted both requesters");

   // Reads answer exactly one cycle later
   fetch_rsp_next: assert property (@(posedge clk) disable iff (rst)
      fetch_read |=> fetch_rsp) else $error("fetch read got no response");
   host_rsp_next: assert property (@(posedge clk) disable iff (rst)
      host_read |=> host_rsp) else $error("host read got no response");

   ua_hold: assert property (@(posedge clk) disable iff (rst)
      ua_valid && !ua_ready |=> ua_valid && $stable(ua)) else $error("ua dropped");
   csbits_hold: assert property (@(posedge clk) disable iff (rst)
      csbits_valid && !csbits_ready |=> csbits_valid && $stable(csbits))
      else $error("csbits changed while stalled");
   cmd_hold: assert property (@(posedge clk) disable iff (rst)
      cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_bits))
      else $error("command changed while waiting");
   rd_hold: assert property (@(posedge clk) disable iff (rst)
      rd_valid && !rd_ready |=> rd_valid && $stable(rd_data))
      else $error("rd_data changed while stalled");

endmodule

bind control_store cs_props i_cs_props (
   .clk          (clk),
   .rst          (rst),
   .fetch_grant  (fetch_bus.req_valid & fetch_bus.req_ready),
   .host_grant   (host_bus.req_valid & host_bus.req_ready),
   .fetch_read   (fetch_bus.req_valid & fetch_bus.req_ready & ~|fetch_bus.lane_we),
   .host_read    (host_bus.req_valid & host_bus.req_ready & ~|host_bus.lane_we),
   .fetch_rsp    (fetch_bus.rsp_valid),
   .host_rsp     (host_bus.rsp_valid),
   .ua_valid     (ua_valid),
   .ua_ready     (ua_ready),
   .ua           (ua),
   .csbits_valid (csbits_valid),
   .csbits_ready (csbits_ready),
   .csbits       (csbits),
   .cmd_valid    (cmd_valid),
   .cmd_ready    (cmd_ready),
   .cmd_bits     ({cmd_write, cmd_addr, cmd_lane, cmd_data}),
   .rd_valid     (rd_valid),
   .rd_ready     (rd_ready),
   .rd_data      (rd_data)
);

//--- testbench/tb_control_store.sv
`timescale 1ns/1ps

module tb_control_store;

   localparam int wait_limit  = 300;              // Cycles allowed per wait loop
   localparam int fetch_words = 16;               // Fully loaded words for fetching
   localparam logic [11:0] fetch_base = 12'h040;
   localparam logic [11:0] host_base  = 12'h900;  // Host-only words while sharing

   logic        clk;
   logic        rst;
   logic        ua_valid;
   logic        ua_ready;
   logic [11:0] ua;
   logic        csbits_valid;
   logic        csbits_ready;
   logic [63:0] csbits;
   logic        cmd_valid;
   logic        cmd_ready;
   logic        cmd_write;
   logic [11:0] cmd_addr;
   logic [1:0]  cmd_lane;
   logic [15:0] cmd_data;
   logic        rd_valid;
   logic        rd_ready;
   logic [15:0] rd_data;

   logic [63:0] shadow [4096];      // Model of the WCS
   logic [3:0]  written [4096];     // Lanes the model knows
   logic [11:0] ua_q [$];           // Accepted microaddresses, oldest first
   logic [31:0] lcg_state = 32'd44219;
   logic        blocked_seen;       // ua_ready low behind a stalled output

   control_store i_control_store (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rnd();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'(lcg_state[31:16]);   // Upper half, low bits repeat quickly
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1, "run stopped");
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   // Hold a command until the port takes it, return just after that edge
   task automatic send_cmd(input logic wr, input logic [11:0] a, input logic [1:0] l,
                           input logic [15:0] d);
      int n;
      cmd_valid = 1'b1;
      cmd_write = wr;
      cmd_addr  = a;
      cmd_lane  = l;
      cmd_data  = d;
      n = 0;
      @(negedge clk);
      while (!cmd_ready) begin
         n++;
         if (n > wait_limit) fail_run("timeout waiting for cmd_ready");
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic host_write(input logic [11:0] a, input logic [1:0] l, input logic [15:0] d);
      shadow[a][int'(l)*16 +: 16] = d;
      written[a][l] = 1'b1;
      send_cmd(1'b1, a, l, d);
   endtask

   task automatic host_read(input logic [11:0] a, input logic [1:0] l);
      int n;
      logic [15:0] exp;
      logic        seen;
      exp = shadow[a][int'(l)*16 +: 16];
      rd_ready = (rnd() % 2) == 0;   // Ready early takes the live data path
      send_cmd(1'b0, a, l, 16'h0);
      n = 0;
      @(negedge clk);
      while (!(rd_valid && rd_ready)) begin
         n++;
         if (n > wait_limit) fail_run("timeout waiting for rd_valid");
         seen = rd_valid;                 // Response left waiting a cycle
         @(posedge clk);
         #1;
         if (seen) rd_ready = 1'b1;       // Held slice path
         @(negedge clk);
      end
      check_eq("rd_data", 64'(rd_data), 64'(exp));
      @(posedge clk);
      #1;
      rd_ready = 1'b0;
   endtask

   task automatic drive_fetch(input int count);
      int n;
      for (int i = 0; i < count; i++) begin
         ua_valid = 1'b1;
         ua = fetch_base + 12'(rnd() % fetch_words);
         n = 0;
         @(negedge clk);
         while (!ua_ready) begin
            if (csbits_valid && !csbits_ready) blocked_seen = 1'b1;
            n++;
            if (n > wait_limit) fail_run("timeout waiting for ua_ready");
            @(negedge clk);
         end
         ua_q.push_back(ua);
         @(posedge clk);
         #1;
      end
      ua_valid = 1'b0;
   endtask

   // Output side, with ready stalled for random stretches
   task automatic collect_fetch(input int count, input int stall_pct);
      int got;
      int idle;
      int hold;
      logic [11:0] a;
      got = 0;
      idle = 0;
      hold = 0;
      while (got < count) begin
         if (hold == 0) begin
            csbits_ready = (rnd() % 100) >= stall_pct;
            hold = 1 + rnd() % 6;
         end
         hold--;
         @(negedge clk);
         if (csbits_valid && csbits_ready) begin
            if (ua_q.size() == 0) fail_run("microword returned with no fetch pending");
            a = ua_q.pop_front();
            check_eq("csbits", csbits, shadow[a]);
            got++;
            idle = 0;
         end else begin
            idle++;
            if (idle > wait_limit) fail_run("timeout waiting for csbits_valid");
         end
         @(posedge clk);
         #1;
      end
      csbits_ready = 1'b0;
   endtask

   task automatic run_fetch(input int count, input int stall_pct);
      fork
         drive_fetch(count);
         collect_fetch(count, stall_pct);
      join
   endtask

   // Host traffic confined to its own region
   task automatic host_mix(input int count);
      logic [11:0] a;
      logic [1:0]  l;
      repeat (count) begin
         a = host_base + 12'(rnd() % 8);
         l = 2'(rnd());
         host_write(a, l, 16'(rnd()));
         host_read(a, l);
         a = host_base + 12'(rnd() % 8);
         l = 2'(rnd());
         if (written[a][l]) host_read(a, l);
      end
   endtask

   initial begin
      logic [11:0] a;
      logic [1:0]  l;
      foreach (written[i]) written[i] = 4'h0;
      rst = 1'b1;
      ua_valid = 1'b0;
      ua = 12'h0;
      csbits_ready = 1'b0;
      cmd_valid = 1'b0;
      cmd_write = 1'b0;
      cmd_addr = 12'h0;
      cmd_lane = 2'd0;
      cmd_data = 16'h0;
      rd_ready = 1'b0;
      blocked_seen = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      @(negedge clk);
      check_eq("csbits_valid", 64'(csbits_valid), 64'd0);
      check_eq("rd_valid", 64'(rd_valid), 64'd0);
      check_eq("cmd_ready", 64'(cmd_ready), 64'd1);
      @(posedge clk);
      #1;

      // Load every slice of the fetch region, then read back at random
      for (int w = 0; w < fetch_words; w++) begin
         for (int s = 0; s < 4; s++) begin
            host_write(fetch_base + 12'(w), 2'(s), 16'(rnd()));
         end
      end
      repeat (32) begin
         a = fetch_base + 12'(rnd() % fetch_words);
         host_read(a, 2'(rnd()));
      end
      repeat (12) begin
         a = 12'(rnd());
         l = 2'(rnd());
         host_write(a, l, 16'(rnd()));
         host_read(a, l);
      end

      // Single lane rewrite, other three must survive
      repeat (8) begin
         a = fetch_base + 12'(rnd() % fetch_words);
         host_write(a, 2'(rnd()), 16'(rnd()));
         for (int s = 0; s < 4; s++) begin
            host_read(a, 2'(s));
         end
      end

      run_fetch(40, 0);
      run_fetch(60, 60);
      if (!blocked_seen) fail_run("ua_ready never dropped while csbits was stalled");

      // Both peers at once on separate regions
      fork
         run_fetch(80, 20);
         host_mix(24);
      join

      // Every word was taken, nothing extra left behind
      @(negedge clk);
      check_eq("csbits_valid", 64'(csbits_valid), 64'd0);

      $display("** PASS **");
      $finish;
   end

endmodule

//--- build.f
verilog/cs_pkg.sv
verilog/cs_bus_if.sv
verilog/cs_wcs.sv
verilog/cs_arbiter.sv
verilog/cs_fetch_port.sv
verilog/cs_host_port.sv
verilog/control_store.sv
testbench/cs_props.sv
testbench/tb_control_store.sv

//--- run_sim.sh
#!/bin/sh
# Build the control store testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_control_store \
   -f build.f -o tb_control_store
./obj_dir/tb_control_store
